// ==== karat_mul.f ====
+incdir+include
src/karat_pkg.sv
src/mult11x11comb.sv
src/mult22x22comb.sv
src/mul_req_in.sv
src/mul_res_out.sv
src/karat_mul_top.sv
tests/tb_karat_mul.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it once
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/1ps \
  --top-module tb_karat_mul \
  -f karat_mul.f \
  -o sim_karat_mul

status=0
./obj_dir/sim_karat_mul > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

grep -q "^TEST RESULT: PASS$" sim.log

// ==== tests/tb_karat_mul.sv ====
`include "karat_consts.svh"

module tb_karat_mul import karat_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  // ============================================================
  // Run length and timeout
  // ============================================================

  localparam int N_UNS         = 200;
  localparam int N_SGN         = 200;
  localparam int N_CORNER      = 50;
  localparam int N_BP          = 60;
  localparam int MAX_ACK_DELAY = 20;
  localparam int TOTAL_REQS    = N_UNS + N_SGN + N_CORNER + N_BP;

  // Each request costs at most the pipeline, the buffer, one output handshake and the ack delay
  localparam int TIMEOUT_CYCLES = TOTAL_REQS * (`KARAT_LAT + 2 + 4 + MAX_ACK_DELAY) * 2;

  // Window after the last expected result in which a stray extra result would show up
  localparam int QUIET_CYCLES = 2 * (`KARAT_LAT + 2 + 4 + MAX_ACK_DELAY);

  localparam logic [31:0] SEED = 32'ha89c_8c58;

  typedef enum {COL_WAIT_REQ, COL_DELAY, COL_WAIT_DROP} col_state_e;

  logic     clk     = 1'b0;
  logic     rst_n   = 1'b0;
  logic     in_req  = 1'b0;
  mul_req_t in_data = '0;
  logic     out_ack = 1'b0;
  logic     in_ack;
  logic     out_req;
  mul_res_t out_data;

  // Expected products in request order
  mul_res_t exp_q [$];

  string       cur_test = "reset_state";
  int          ack_delay_max = 0;
  int          err_count = 0;
  int          check_total = 0;
  int          test_total = 0;
  int          req_count = 0;
  int          res_count = 0;
  int unsigned cycles = 0;

  // Separate generators so the two processes never race for one sequence
  logic [31:0] stim_seed = SEED;
  logic [31:0] col_seed  = ~SEED;
  col_state_e  col_state = COL_WAIT_REQ;
  int          col_wait  = 0;

  karat_mul_top dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_req   (in_req),
    .in_data  (in_data),
    .in_ack   (in_ack),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data)
  );

  always #50 clk = ~clk;

  // ============================================================
  // Helpers
  // ============================================================

  // Numerical Recipes constants where the upper bits are the useful ones
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Reference product straight from the arithmetic definition
  function automatic mul_res_t model_product(input mul_req_t r);
    logic signed [`KARAT_PW-1:0] sa, sb;
    mul_res_t res;
    if (r.op == MUL_S) begin
      sa = {{(`KARAT_PW-`KARAT_W){r.a[`KARAT_W-1]}}, r.a};
      sb = {{(`KARAT_PW-`KARAT_W){r.b[`KARAT_W-1]}}, r.b};
      res.prod = sa * sb;
    end else begin
      res.prod = {{(`KARAT_PW-`KARAT_W){1'b0}}, r.a} * {{(`KARAT_PW-`KARAT_W){1'b0}}, r.b};
    end
    return res;
  endfunction

  task automatic check_res(input string name, input mul_res_t exp, input mul_res_t act);
    check_total++;
    if (act !== exp) begin
      $display("Fail %s: expected 0x%h, actual 0x%h", name, exp.prod, act.prod);
      err_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    check_total++;
    if (act !== exp) begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    check_total++;
    if (act != exp) begin
      $display("Fail %s: expected %0d, actual %0d", name, exp, act);
      err_count++;
    end
  endtask

  // Pops the oldest expected value and compares it with what came out
  task automatic take_result(input mul_res_t act);
    mul_res_t exp;
    res_count++;
    if (exp_q.size() == 0) begin
      $display("Error in %s: result 0x%h arrived with no request outstanding",
               cur_test, act.prod);
      err_count++;
    end else begin
      exp = exp_q.pop_front();
      check_res($sformatf("%s result %0d", cur_test, res_count), exp, act);
    end
  endtask

  // Runs a full four-phase request and returns once in_ack has dropped again
  task automatic send_req(input mul_op_e op, input logic [`KARAT_W-1:0] a,
                          input logic [`KARAT_W-1:0] b);
    mul_req_t r;
    r = '{op: op, a: a, b: b};
    exp_q.push_back(model_product(r));
    req_count++;
    @(posedge clk);
    in_data <= r;
    in_req  <= 1'b1;
    do @(posedge clk); while (!in_ack);
    in_req <= 1'b0;
    do @(posedge clk); while (in_ack);
  endtask

  // Mode 0 is unsigned, 1 is signed, 2 picks the opcode at random
  task automatic send_random(input int n, input int mode);
    logic [`KARAT_W-1:0] a, b;
    mul_op_e             op;
    for (int i = 0; i < n; i++) begin
      stim_seed = lcg_next(stim_seed);
      a = stim_seed[31:10];
      op = (mode == 2) ? mul_op_e'(stim_seed[9]) : mul_op_e'(mode == 1);
      stim_seed = lcg_next(stim_seed);
      b = stim_seed[31:10];
      send_req(op, a, b);
    end
  endtask

  task automatic run_test(input string name, input int n, input int mode, input int dly);
    int err_mark, req_mark, res_mark;
    logic [`KARAT_W-1:0] corner [5];
    err_mark = err_count;
    req_mark = req_count;
    res_mark = res_count;
    cur_test = name;
    ack_delay_max = dly;
    test_total++;
    if (mode == 3) begin
      // Zero, one, all ones, most negative and most positive
      corner = '{22'h000000, 22'h000001, 22'h3fffff, 22'h200000, 22'h1fffff};
      for (int k = 0; k < 2; k++) begin
        for (int i = 0; i < 5; i++) begin
          for (int j = 0; j < 5; j++) begin
            send_req(k ? MUL_S : MUL_U, corner[i], corner[j]);
          end
        end
      end
    end else begin
      send_random(n, mode);
    end
    // Drain everything still in flight, then give a duplicate time to appear
    while (res_count < req_count) @(posedge clk);
    repeat (QUIET_CYCLES) @(posedge clk);
    check_count({name, " result count"}, req_count - req_mark, res_count - res_mark);
    $display("Test %-18s done: %0d requests, %0d errors",
             name, req_count - req_mark, err_count - err_mark);
  endtask

  // ============================================================
  // Output collector with a random ack delay
  // ============================================================

  always @(posedge clk) begin
    if (!rst_n) begin
      out_ack   <= 1'b0;
      col_state = COL_WAIT_REQ;
    end else begin
      case (col_state)
        COL_WAIT_REQ: begin
          if (out_req) begin
            take_result(out_data);
            col_seed = lcg_next(col_seed);
            col_wait = int'(col_seed[31:16]) % (ack_delay_max + 1);
            if (col_wait == 0) begin
              out_ack   <= 1'b1;
              col_state = COL_WAIT_DROP;
            end else begin
              col_state = COL_DELAY;
            end
          end
        end
        COL_DELAY: begin
          col_wait--;
          if (col_wait == 0) begin
            out_ack   <= 1'b1;
            col_state = COL_WAIT_DROP;
          end
        end
        COL_WAIT_DROP: begin
          // Ack drops only after the unit has withdrawn its request
          if (!out_req) begin
            out_ack   <= 1'b0;
            col_state = COL_WAIT_REQ;
          end
        end
        default: col_state = COL_WAIT_REQ;
      endcase
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d of %0d results collected",
               cycles, res_count, req_count);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // ============================================================
  // Test sequence
  // ============================================================

  initial begin
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // Both handshake outputs idle before anything is requested
    test_total++;
    repeat (10) begin
      @(posedge clk);
      check_bit("reset_state in_ack", 1'b0, in_ack);
      check_bit("reset_state out_req", 1'b0, out_req);
    end
    $display("Test %-18s done: %0d requests, %0d errors", "reset_state", 0, err_count);

    run_test("unsigned_products", N_UNS, 0, 0);
    run_test("signed_products", N_SGN, 1, 0);
    run_test("corner_operands", N_CORNER, 3, 0);
    run_test("back_pressure", N_BP, 2, MAX_ACK_DELAY);

    $display("Summary: %0d tests, %0d checks, %0d errors, %0d results",
             test_total, check_total, err_count, res_count);
    if (err_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== src/karat_mul_top.sv ====
`include "karat_consts.svh"

module karat_mul_top import karat_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_req,
  input  mul_req_t in_data,
  output logic     in_ack,
  output logic     out_req,
  input  logic     out_ack,
  output mul_res_t out_data
);

  // Pipeline enable, driven by the result buffer
  logic ce;

  mul_issue_t           issue;
  logic [`KARAT_PW-1:0] prod;
  mul_tag_t             tag;

  // Input side turns requests into unsigned issues
  mul_req_in u_req_in (
    .clk     (clk),
    .rst_n   (rst_n),
    .ce      (ce),
    .in_req  (in_req),
    .in_data (in_data),
    .in_ack  (in_ack),
    .issue   (issue)
  );

  mult22x22comb u_mul (
    .clk   (clk),
    .rst_n (rst_n),
    .ce    (ce),
    .issue (issue),
    .o     (prod),
    .tag_o (tag)
  );

  // Output side restores the sign and applies back-pressure
  mul_res_out u_res_out (
    .clk      (clk),
    .rst_n    (rst_n),
    .prod     (prod),
    .tag      (tag),
    .ce       (ce),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data)
  );

endmodule

// ==== src/mul_res_out.sv ====
`include "karat_consts.svh"

module mul_res_out import karat_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [`KARAT_PW-1:0] prod,
  input  mul_tag_t             tag,
  output logic                 ce,
  output logic                 out_req,
  input  logic                 out_ack,
  output mul_res_t             out_data
);

  // ============================================================
  // Result buffer
  // ============================================================

  mul_res_t mem [`KARAT_BUF];

  logic [$clog2(`KARAT_BUF)-1:0]   wr_ptr, rd_ptr;
  logic [$clog2(`KARAT_BUF+1)-1:0] count;

  hs_state_e state;

  logic                 wr_en, rd_en;
  logic [`KARAT_PW-1:0] res_val;

  // Stall the pipeline only when there is no room for its next product
  assign ce = (count != `KARAT_BUF);

  assign wr_en = tag.valid && ce;

  // The entry is released once the consumer has dropped its ack
  assign rd_en = (state == HS_WAIT_LOW) && !out_ack;

  // Restore the sign by negating modulo 2^44
  assign res_val = tag.neg ? (~prod + 1'b1) : prod;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= '{prod: res_val};
    end
  end

  // Depth is a power of two so the pointers simply wrap
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (!wr_en && rd_en) begin
        count <= count - 1'b1;
      end
    end
  end

  // ============================================================
  // Output handshake FSM
  // ============================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= HS_IDLE;
      out_req <= 1'b0;
    end else begin
      case (state)
        HS_IDLE: begin
          if (count != '0) begin
            out_req <= 1'b1;
            state   <= HS_ACK;
          end
        end
        HS_ACK: begin
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= HS_WAIT_LOW;
          end
        end
        HS_WAIT_LOW: begin
          if (!out_ack) begin
            state <= HS_IDLE;
          end
        end
        default: state <= HS_IDLE;
      endcase
    end
  end

  // The oldest entry is never overwritten while it is presented
  assign out_data = mem[rd_ptr];

  // A write never lands on an entry that is still waiting to be read
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> ((count == '0) || (wr_ptr != rd_ptr))
  );

  // A stalled pipeline must keep its finished product waiting at the output
  a_stall_holds: assert property (
    @(posedge clk) disable iff (!rst_n)
    (tag.valid && !ce) |=> (tag.valid && $stable(prod))
  );

  a_out_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_req ##1 out_req |-> $stable(out_data)
  );

endmodule

// ==== src/mul_req_in.sv ====
`include "karat_consts.svh"

module mul_req_in import karat_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ce,
  input  logic       in_req,
  input  mul_req_t   in_data,
  output logic       in_ack,
  output mul_issue_t issue
);

  hs_state_e state;

  logic                a_neg, b_neg;
  logic [`KARAT_W-1:0] a_mag, b_mag;

  // Issue register that feeds the core
  logic                iss_valid, iss_neg;
  logic [`KARAT_W-1:0] iss_a, iss_b;

  // ============================================================
  // Operand conditioning
  // ============================================================

  // Only signed requests look at the top bits
  always_comb begin
    a_neg = (in_data.op == MUL_S) && in_data.a[`KARAT_W-1];
    b_neg = (in_data.op == MUL_S) && in_data.b[`KARAT_W-1];
    // The most negative value maps to 2^21, which still fits unsigned
    a_mag = a_neg ? (~in_data.a + 1'b1) : in_data.a;
    b_mag = b_neg ? (~in_data.b + 1'b1) : in_data.b;
  end

  // ============================================================
  // Handshake FSM
  // ============================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state  <= HS_IDLE;
      in_ack <= 1'b0;
    end else begin
      case (state)
        HS_IDLE: begin
          // Acceptance waits while the pipeline is frozen
          if (in_req && ce) begin
            in_ack <= 1'b1;
            state  <= HS_ACK;
          end
        end
        HS_ACK: begin
          if (!in_req) begin
            in_ack <= 1'b0;
            state  <= HS_WAIT_LOW;
          end
        end
        HS_WAIT_LOW: state <= HS_IDLE;
        default:     state <= HS_IDLE;
      endcase
    end
  end

  // Valid lasts exactly one enabled cycle and the core takes it on the next one
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      iss_valid <= 1'b0;
    end else if (ce) begin
      iss_valid <= (state == HS_IDLE) && in_req;
    end
  end

  always_ff @(posedge clk) begin
    if (ce && (state == HS_IDLE) && in_req) begin
      iss_neg <= a_neg ^ b_neg;
      iss_a   <= a_mag;
      iss_b   <= b_mag;
    end
  end

  assign issue = '{tag: '{valid: iss_valid, neg: iss_neg}, a: iss_a, b: iss_b};

  // The environment keeps the request data still until it is acknowledged
  a_data_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (in_req && !in_ack) ##1 (in_req && !in_ack) |-> $stable(in_data)
  );

  // A request stays up until it has been acknowledged
  a_req_held: assert property (
    @(posedge clk) disable iff (!rst_n)
    (in_req && !in_ack) |=> in_req
  );

endmodule

// ==== src/mult22x22comb.sv ====
`include "karat_consts.svh"

module mult22x22comb import karat_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ce,
  input  mul_issue_t           issue,
  output logic [`KARAT_PW-1:0] o,
  output mul_tag_t             tag_o
);

  // ============================================================
  // Stage registers
  // ============================================================

  // Stage 1 holds the halves and their signed differences
  logic [`KARAT_H-1:0] s1_a_hi, s1_a_lo, s1_b_hi, s1_b_lo;
  logic [`KARAT_H:0]   s1_da, s1_db;
  logic                s1_sgn;

  // Stage 2 holds the three partial products
  logic [`KARAT_W-1:0] s2_z2, s2_z0, s2_p3;
  logic                s2_sgn;

  // Stages 3 and 4 negate the middle product in two steps
  logic [`KARAT_W-1:0] s3_z2, s3_z0, s4_z2, s4_z0;
  logic [`KARAT_W:0]   s3_p3x, s4_p4;
  logic                s3_sgn;

  // Stage 5 holds the middle term of the Karatsuba sum
  logic [`KARAT_W-1:0] s5_z2, s5_z0;
  logic [`KARAT_W:0]   s5_z1;

  // Tag shift register with one slot per stage
  mul_tag_t tag_sr [`KARAT_LAT];

  // Magnitudes of the differences feeding the middle multiplier
  logic [`KARAT_H-1:0] da_mag, db_mag;
  logic [`KARAT_W-1:0] z2, z0, p3;

  // x0-x1 and y1-y0 are at most 2047 in size so 11 bits hold the magnitude
  assign da_mag = s1_da[`KARAT_H] ? `KARAT_H'(-s1_da) : s1_da[`KARAT_H-1:0];
  assign db_mag = s1_db[`KARAT_H] ? `KARAT_H'(-s1_db) : s1_db[`KARAT_H-1:0];

  mult11x11comb u_hi (.a(s1_a_hi), .b(s1_b_hi), .o(z2));
  mult11x11comb u_lo (.a(s1_a_lo), .b(s1_b_lo), .o(z0));
  mult11x11comb u_md (.a(da_mag), .b(db_mag), .o(p3));

  // ============================================================
  // Datapath, advances only on enabled cycles
  // ============================================================

  always_ff @(posedge clk) begin
    if (ce) begin
      s1_a_hi <= issue.a[`KARAT_W-1:`KARAT_H];
      s1_a_lo <= issue.a[`KARAT_H-1:0];
      s1_b_hi <= issue.b[`KARAT_W-1:`KARAT_H];
      s1_b_lo <= issue.b[`KARAT_H-1:0];
      s1_da   <= {1'b0, issue.a[`KARAT_H-1:0]} - {1'b0, issue.a[`KARAT_W-1:`KARAT_H]};
      s1_db   <= {1'b0, issue.b[`KARAT_W-1:`KARAT_H]} - {1'b0, issue.b[`KARAT_H-1:0]};
      // Sign of the middle product, taken from the raw differences
      s1_sgn  <= (issue.a[`KARAT_H-1:0] < issue.a[`KARAT_W-1:`KARAT_H]) ^
                 (issue.b[`KARAT_W-1:`KARAT_H] < issue.b[`KARAT_H-1:0]);

      s2_z2  <= z2;
      s2_z0  <= z0;
      s2_p3  <= p3;
      s2_sgn <= s1_sgn;

      // Invert first and add the +1 of the two's complement in the next stage
      s3_z2  <= s2_z2;
      s3_z0  <= s2_z0;
      s3_p3x <= {1'b0, s2_p3} ^ {(`KARAT_W+1){s2_sgn}};
      s3_sgn <= s2_sgn;

      s4_z2 <= s3_z2;
      s4_z0 <= s3_z0;
      s4_p4 <= s3_p3x + {{`KARAT_W{1'b0}}, s3_sgn};

      // z1 = x1*y0 + x0*y1 is never negative so modulo arithmetic is exact
      s5_z2 <= s4_z2;
      s5_z0 <= s4_z0;
      s5_z1 <= s4_p4 + {1'b0, s4_z2} + {1'b0, s4_z0};

      o <= {s5_z2, s5_z0} + {{(`KARAT_H-1){1'b0}}, s5_z1, {`KARAT_H{1'b0}}};
    end
  end

  // Tags move with the data through the same enabled stages
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `KARAT_LAT; i++) begin
        tag_sr[i] <= '0;
      end
    end else if (ce) begin
      tag_sr[0] <= issue.tag;
      for (int i = 1; i < `KARAT_LAT; i++) begin
        tag_sr[i] <= tag_sr[i-1];
      end
    end
  end

  assign tag_o = tag_sr[`KARAT_LAT-1];

  // The input side offers each operation for one enabled cycle only
  a_issue_once: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ce && issue.tag.valid) |=> !issue.tag.valid
  );

endmodule

// ==== src/mult11x11comb.sv ====
`include "karat_consts.svh"

module mult11x11comb (
  input  logic [`KARAT_H-1:0] a,
  input  logic [`KARAT_H-1:0] b,
  output logic [`KARAT_W-1:0] o
);

  // One partial product per bit of b, each already shifted into place
  logic [`KARAT_W-1:0] pp [`KARAT_H];

  // Tree levels, five pairs then three then two
  logic [`KARAT_W-1:0] lv1 [5];
  logic [`KARAT_W-1:0] lv2 [3];
  logic [`KARAT_W-1:0] lv3;

  always_comb begin
    for (int i = 0; i < `KARAT_H; i++) begin
      pp[i] = b[i] ? ({{`KARAT_H{1'b0}}, a} << i) : '0;
    end
  end

  // First level adds neighbouring pairs, pp[10] waits for level two
  always_comb begin
    for (int j = 0; j < 5; j++) begin
      lv1[j] = pp[2*j] + pp[2*j+1];
    end
  end

  always_comb begin
    lv2[0] = lv1[0] + lv1[1];
    lv2[1] = lv1[2] + lv1[3];
    lv2[2] = lv1[4] + pp[10];
  end

  // Last two levels, the odd branch joins at the very end
  always_comb begin
    lv3 = lv2[0] + lv2[1];
    o   = lv3 + lv2[2];
  end

endmodule

// ==== src/karat_pkg.sv ====
`include "karat_consts.svh"

package karat_pkg;

  // Opcode carried with each request
  typedef enum logic {
    MUL_U = 1'b0,
    MUL_S = 1'b1
  } mul_op_e;

  // Four-phase handshake state, shared by both ports
  typedef enum logic [1:0] {
    HS_IDLE     = 2'd0,
    HS_ACK      = 2'd1,
    HS_WAIT_LOW = 2'd2
  } hs_state_e;

  // Request as seen on the input port
  typedef struct packed {
    mul_op_e                op;
    logic [`KARAT_W-1:0]    a;
    logic [`KARAT_W-1:0]    b;
  } mul_req_t;

  // Tag that rides alongside the data through the pipeline
  typedef struct packed {
    logic valid;
    logic neg;
  } mul_tag_t;

  // One operation entering the core, operands already as magnitudes
  typedef struct packed {
    mul_tag_t               tag;
    logic [`KARAT_W-1:0]    a;
    logic [`KARAT_W-1:0]    b;
  } mul_issue_t;

  typedef struct packed {
    logic [`KARAT_PW-1:0] prod;
  } mul_res_t;

endpackage

// ==== include/karat_consts.svh ====
`ifndef KARAT_CONSTS_SVH
`define KARAT_CONSTS_SVH

// ============================================================
// Fixed widths of the 22x22 Karatsuba multiply unit
// ============================================================

// Operand width, the split below only works for this width
`define KARAT_W   22

// Half width, both halves are 11 bits wide
`define KARAT_H   11

// Full product width
`define KARAT_PW  44

// Enabled cycles from issue to product out of the core
`define KARAT_LAT 6

// Number of entries in the result buffer
`define KARAT_BUF 2

`endif
